// ==== Bender.yml ====
package:
  name: hexlog

sources:
  - hexLogPkg.sv
  - hexLogRegs.sv
  - hexFormatter.sv
  - uartTx.sv
  - hexLogTop.sv
  - target: test
    files:
      - hexLogTop_asserts.sv
      - hexLogTop_tb.sv

// ==== hexFormatter.sv ====
// --------------------
// Turns a 16-bit word into four upper-case hex characters and a line feed
// Takes words on a valid/ready pair and emits characters the same way
// --------------------
`timescale 1ns/100ps

module hexFormatter (
	input  logic                  iCLK,
	input  logic                  iRST,
	// Word input
	input  logic                  wordValid,
	output logic                  wordReady,
	input  hexLogPkg::logWord_t   word,
	output logic                  fmtBusy,
	// Character output
	output logic                  charValid,
	input  logic                  charReady,
	output hexLogPkg::asciiChar_t char
);

	import hexLogPkg::*;

	typedef logic [$clog2(NIBBLE_COUNT)-1:0] nibIdx_t;

	fmtState_t state;
	nibIdx_t   nibbleIdx;   // Counts down from the top nibble
	logWord_t  wordReg;
	logic      charXfer;
	logic [3:0] nibble;

	// Nibble to ASCII, 0-9 then A-F
	function automatic asciiChar_t hexChar(input logic [3:0] nib);
		if (nib < 4'd10)
		begin
			return 8'h30 + {4'h0, nib};
		end
		return 8'h37 + {4'h0, nib};
	endfunction

	assign wordReady = (state == FMT_IDLE);
	assign fmtBusy   = (state != FMT_IDLE);
	assign charValid = (state != FMT_IDLE);
	assign charXfer  = charValid & charReady;

	assign nibble = wordReg[{nibbleIdx, 2'b00} +: 4];
	assign char   = (state == FMT_WAIT) ? LINE_END_CHAR : hexChar(nibble);

	// --------------------
	// Sequencer
	// --------------------
	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			state     <= FMT_IDLE;
			nibbleIdx <= '0;
		end
		else
		begin
			case (state)
				FMT_IDLE:
				begin
					if (wordValid)
					begin
						state     <= FMT_EMIT;
						nibbleIdx <= nibIdx_t'(NIBBLE_COUNT - 1);
					end
				end
				FMT_EMIT:
				begin
					if (charXfer)
					begin
						if (nibbleIdx == '0)
						begin
							state <= FMT_WAIT;   // Last digit gone, line feed next
						end
						else
						begin
							nibbleIdx <= nibbleIdx - 1'b1;
						end
					end
				end
				FMT_WAIT:
				begin
					if (charXfer) state <= FMT_IDLE;
				end
				default: state <= FMT_IDLE;
			endcase
		end
	end

	// Word capture on accept
	always_ff @(posedge iCLK)
	begin
		if (wordValid && wordReady)
		begin
			wordReg <= word;
		end
	end

endmodule

// ==== hexLogPkg.sv ====
// --------------------
// Shared widths, register map and FSM encodings for the hex logger
// Imported by every block of the logger and by its testbench
// --------------------
package hexLogPkg;

	// --------------------
	// Widths
	// --------------------
	localparam int WB_DATA_WIDTH  = 32;
	localparam int WB_ADDR_WIDTH  = 2;
	localparam int LOG_WORD_WIDTH = 16;
	localparam int NIBBLE_COUNT   = 4;   // Hex characters per logged word
	localparam int CHAR_WIDTH     = 8;
	localparam int BAUD_DIV_WIDTH = 16;

	typedef logic [WB_DATA_WIDTH-1:0]  wbData_t;
	typedef logic [WB_ADDR_WIDTH-1:0]  wbAddr_t;
	typedef logic [LOG_WORD_WIDTH-1:0] logWord_t;
	typedef logic [CHAR_WIDTH-1:0]     asciiChar_t;
	typedef logic [BAUD_DIV_WIDTH-1:0] baudDiv_t;   // Bit lasts divisor + 1 cycles

	// --------------------
	// Register map
	// --------------------
	localparam wbAddr_t ADDR_DATA   = 2'd0;
	localparam wbAddr_t ADDR_STATUS = 2'd1;
	localparam wbAddr_t ADDR_BAUD   = 2'd2;   // Address 3 reads zero

	localparam baudDiv_t   DEFAULT_BAUD_DIV = 16'd15;
	localparam asciiChar_t LINE_END_CHAR    = 8'h0A;   // Line feed

	// Formatter FSM
	typedef enum logic [1:0] {
		FMT_IDLE,
		FMT_EMIT,   // Hex digits going out
		FMT_WAIT    // Line feed going out
	} fmtState_t;

	// Serializer FSM
	typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} txState_t;

endpackage

// ==== hexLogRegs.sv ====
// --------------------
// Wishbone classic slave with the data, status and baud registers
// DATA writes are held until the formatter takes the word
// --------------------
`timescale 1ns/100ps

module hexLogRegs (
	input  logic               iCLK,
	input  logic               iRST,
	// Wishbone slave
	input  logic               wbCyc,
	input  logic               wbStb,
	input  logic               wbWe,
	input  hexLogPkg::wbAddr_t wbAdr,
	input  hexLogPkg::wbData_t wbDatW,
	output hexLogPkg::wbData_t wbDatR,
	output logic               wbAck,
	// Word handshake toward the formatter
	output logic               wordValid,
	input  logic               wordReady,
	output hexLogPkg::logWord_t word,
	// Status and configuration
	input  logic               fmtBusy,
	input  logic               txBusy,
	output hexLogPkg::baudDiv_t baudDiv
);

	import hexLogPkg::*;

	logic    access;
	logic    dataWrite;
	logic    wordXfer;
	wbData_t readMux;

	assign access    = wbCyc & wbStb;
	assign dataWrite = wbWe && (wbAdr == ADDR_DATA);
	assign wordXfer  = wordValid & wordReady;

	// --------------------
	// Ack generation
	// --------------------
	// Plain accesses ack one cycle after they are seen; DATA writes ack
	// one cycle after the word is handed over
	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			wbAck <= 1'b0;
		end
		else
		begin
			wbAck <= (access & ~dataWrite & ~wbAck) | wordXfer;
		end
	end

	// Word hand-off
	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			wordValid <= 1'b0;
		end
		else if (wordXfer)
		begin
			wordValid <= 1'b0;
		end
		else if (access && dataWrite && !wordValid && !wbAck)
		begin
			wordValid <= 1'b1;   // Word is latched below in the same cycle
		end
	end

	always_ff @(posedge iCLK)
	begin
		if (access && dataWrite && !wordValid && !wbAck)
		begin
			word <= wbDatW[LOG_WORD_WIDTH-1:0];
		end
	end

	// Divisor register
	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			baudDiv <= DEFAULT_BAUD_DIV;
		end
		else if (access && wbWe && (wbAdr == ADDR_BAUD) && !wbAck)
		begin
			baudDiv <= wbDatW[BAUD_DIV_WIDTH-1:0];
		end
	end

	// --------------------
	// Read data
	// --------------------
	always_comb
	begin
		case (wbAdr)
			ADDR_STATUS: readMux = wbData_t'({txBusy, fmtBusy});
			ADDR_BAUD:   readMux = wbData_t'(baudDiv);
			default:     readMux = '0;   // DATA is write only
		endcase
	end

	always_ff @(posedge iCLK)
	begin
		wbDatR <= readMux;   // Valid in the ack cycle
	end

endmodule

// ==== hexLogTop.f ====
hexLogPkg.sv
hexLogRegs.sv
hexFormatter.sv
uartTx.sv
hexLogTop.sv
hexLogTop_asserts.sv
hexLogTop_tb.sv

// ==== hexLogTop.sv ====
// --------------------
// Hex logger top: Wishbone registers, hex formatter and UART transmitter
// --------------------
`timescale 1ns/100ps

module hexLogTop (
	input  logic               iCLK,
	input  logic               iRST,
	input  logic               wbCyc,
	input  logic               wbStb,
	input  logic               wbWe,
	input  hexLogPkg::wbAddr_t wbAdr,
	input  hexLogPkg::wbData_t wbDatW,
	output hexLogPkg::wbData_t wbDatR,
	output logic               wbAck,
	output logic               txLine
);

	import hexLogPkg::*;

	logic       wordValid;
	logic       wordReady;
	logWord_t   word;
	logic       charValid;
	logic       charReady;
	asciiChar_t char;
	logic       fmtBusy;
	logic       txBusy;
	baudDiv_t   baudDiv;

	hexLogRegs hexLogRegs_inst (
		.iCLK(iCLK), .iRST(iRST),
		.wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr),
		.wbDatW(wbDatW), .wbDatR(wbDatR), .wbAck(wbAck),
		.wordValid(wordValid), .wordReady(wordReady), .word(word),
		.fmtBusy(fmtBusy), .txBusy(txBusy), .baudDiv(baudDiv)
	);

	hexFormatter hexFormatter_inst (
		.iCLK(iCLK), .iRST(iRST),
		.wordValid(wordValid), .wordReady(wordReady), .word(word), .fmtBusy(fmtBusy),
		.charValid(charValid), .charReady(charReady), .char(char)
	);

	uartTx uartTx_inst (
		.iCLK(iCLK), .iRST(iRST),
		.charValid(charValid), .charReady(charReady), .char(char),
		.baudDiv(baudDiv), .txBusy(txBusy), .txLine(txLine)
	);

endmodule

// ==== hexLogTop_asserts.sv ====
// --------------------
// Concurrent checks on the logger handshakes and the serial line
// Bound into hexLogTop from the testbench
// --------------------
`timescale 1ns/100ps

module hexLogTop_asserts (
	input logic                  iCLK,
	input logic                  iRST,
	input logic                  wbAck,
	input logic                  wordValid,
	input logic                  wordReady,
	input hexLogPkg::logWord_t   word,
	input logic                  charValid,
	input logic                  charReady,
	input hexLogPkg::asciiChar_t char,
	input logic                  txBusy,
	input logic                  txLine
);

	// Ack is a single-cycle pulse
	ackPulse: assert property (@(posedge iCLK) disable iff (iRST) wbAck |=> !wbAck)
		else $error("wbAck high for two cycles in a row");

	// Word held stable until the formatter takes it
	wordHold: assert property (@(posedge iCLK) disable iff (iRST)
		wordValid && !wordReady |=> wordValid && $stable(word))
		else $error("wordValid or word changed before the transfer");

	charHold: assert property (@(posedge iCLK) disable iff (iRST)
		charValid && !charReady |=> charValid && $stable(char))
		else $error("charValid or char changed before the transfer");

	lineIdle: assert property (@(posedge iCLK) disable iff (iRST) !txBusy |-> txLine)
		else $error("txLine low while the serializer is idle");

endmodule

// ==== hexLogTop_tb.sv ====
// --------------------
// Directed testbench for the hex logger
// Drives the Wishbone bus and decodes the UART line into a queue
// --------------------
`timescale 1ns/100ps

module hexLogTop_tb;

	import hexLogPkg::*;

	localparam baudDiv_t TEST_BAUD_DIV = 16'd7;   // Divisor from test 2 on
	localparam int TOTAL_CHARS = 45;   // Lines of tests 3 to 6
	localparam int CYCLE_LIMIT = TOTAL_CHARS * 10 * (int'(TEST_BAUD_DIV) + 1) + 1000;
	localparam int ACK_LIMIT   = 2000;

	logic     iCLK;
	logic     iRST;
	logic     wbCyc;
	logic     wbStb;
	logic     wbWe;
	wbAddr_t  wbAdr;
	wbData_t  wbDatW;
	wbData_t  wbDatR;
	logic     wbAck;
	logic     txLine;

	int         errorCount = 0;
	int         checkCount = 0;
	int         cycleCount = 0;
	integer     seed = 32'h19698fff;
	baudDiv_t   curDiv = DEFAULT_BAUD_DIV;   // Divisor the monitor samples with
	asciiChar_t rxQ[$];

	hexLogTop hexLogTop_inst (
		.iCLK(iCLK), .iRST(iRST),
		.wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr),
		.wbDatW(wbDatW), .wbDatR(wbDatR), .wbAck(wbAck), .txLine(txLine)
	);

	bind hexLogTop hexLogTop_asserts hexLogTop_asserts_inst (
		.iCLK(iCLK), .iRST(iRST), .wbAck(wbAck),
		.wordValid(wordValid), .wordReady(wordReady), .word(word),
		.charValid(charValid), .charReady(charReady), .char(char),
		.txBusy(txBusy), .txLine(txLine)
	);

	initial
	begin
		iCLK = 1'b0;
		forever #20 iCLK = ~iCLK;
	end

	// --------------------
	// Check and bus tasks
	// --------------------
	task automatic checkEq(input string name, input wbData_t got, input wbData_t exp);
		checkCount++;
		if (got !== exp)
		begin
			$display("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp);
			errorCount++;
		end
	endtask

	task automatic waitAck(input string what);
		int waited;
		waited = 0;
		@(negedge iCLK);
		while (!wbAck && waited < ACK_LIMIT)
		begin
			@(negedge iCLK);
			waited++;
		end
		if (!wbAck)
		begin
			$display("%s got no ack within %0d cycles", what, ACK_LIMIT);
			errorCount++;
		end
	endtask

	task automatic wbWrite(input wbAddr_t adr, input wbData_t data);
		@(posedge iCLK);
		wbCyc  <= 1'b1;
		wbStb  <= 1'b1;
		wbWe   <= 1'b1;
		wbAdr  <= adr;
		wbDatW <= data;
		waitAck($sformatf("Write to address %0d", adr));
		if (adr == ADDR_BAUD) curDiv = baudDiv_t'(data);
		@(posedge iCLK);
		wbCyc <= 1'b0;
		wbStb <= 1'b0;
		wbWe  <= 1'b0;
	endtask

	task automatic wbRead(input wbAddr_t adr, output wbData_t data);
		@(posedge iCLK);
		wbCyc <= 1'b1;
		wbStb <= 1'b1;
		wbWe  <= 1'b0;
		wbAdr <= adr;
		waitAck($sformatf("Read of address %0d", adr));
		data = wbDatR;   // Sampled in the ack cycle
		@(posedge iCLK);
		wbCyc <= 1'b0;
		wbStb <= 1'b0;
	endtask

	// --------------------
	// UART line monitor
	// --------------------
	initial
	begin
		int         frameDiv;
		asciiChar_t rxByte;
		@(negedge iRST);
		forever
		begin
			@(negedge txLine);
			frameDiv = int'(curDiv);
			repeat (frameDiv / 2 + 1) @(negedge iCLK);   // Middle of start bit
			if (txLine !== 1'b0)
			begin
				$display("Start bit was not low at its middle");
				errorCount++;
			end
			for (int i = 0; i < 8; i++)
			begin
				repeat (frameDiv + 1) @(negedge iCLK);
				rxByte[i] = txLine;   // LSB first
			end
			repeat (frameDiv + 1) @(negedge iCLK);
			if (txLine !== 1'b1)
			begin
				$display("Stop bit was not high at its middle");
				errorCount++;
			end
			rxQ.push_back(rxByte);
		end
	end

	// Expected character k of a logged word with the line feed last
	function automatic asciiChar_t expChar(input logWord_t w, input int k);
		logic [3:0] nib;
		if (k == NIBBLE_COUNT) return LINE_END_CHAR;
		nib = 4'((w >> (4 * (NIBBLE_COUNT - 1 - k))) & 16'hF);
		if (nib <= 4'd9) return asciiChar_t'("0") + nib;
		return asciiChar_t'("A") + (nib - 4'd10);
	endfunction

	task automatic waitChars(input int n);
		int waited;
		int limit;
		waited = 0;
		limit  = n * 10 * (int'(curDiv) + 1) + 200;
		while (rxQ.size() < n && waited < limit)
		begin
			@(negedge iCLK);
			waited++;
		end
		if (rxQ.size() < n)
		begin
			$display("Expected %0d characters from the UART, received %0d", n, rxQ.size());
			errorCount++;
		end
	endtask

	task automatic checkLine(input logWord_t w);
		asciiChar_t got;
		for (int k = 0; k <= NIBBLE_COUNT; k++)
		begin
			if (rxQ.size() == 0)
			begin
				$display("Line for word 0x%04h ended after %0d characters", w, k);
				errorCount++;
				return;
			end
			got = rxQ.pop_front();
			checkEq($sformatf("char %0d of 0x%04h", k, w), got, expChar(w, k));
		end
	endtask

	task automatic reportTest(input string name, input int errsBefore);
		if (errorCount == errsBefore) $display("%s: ok", name);
		else $display("%s: %0d error(s)", name, errorCount - errsBefore);
	endtask

	// --------------------
	// Tests
	// --------------------
	task automatic testReset();
		int      errs;
		wbData_t rd;
		errs = errorCount;
		@(negedge iCLK);
		checkEq("txLine", txLine, 1'b1);
		wbRead(ADDR_STATUS, rd);
		checkEq("STATUS", rd, 0);
		wbRead(ADDR_BAUD, rd);
		checkEq("BAUD", rd, DEFAULT_BAUD_DIV);
		reportTest("reset values", errs);
	endtask

	task automatic testRegisters();
		int      errs;
		wbData_t rd;
		errs = errorCount;
		wbWrite(ADDR_BAUD, wbData_t'(TEST_BAUD_DIV));
		wbRead(ADDR_BAUD, rd);
		checkEq("BAUD", rd, 32'd7);
		wbWrite(2'd3, 32'hFFFF_FFFF);
		wbRead(2'd3, rd);
		checkEq("address 3", rd, 0);
		reportTest("register access", errs);
	endtask

	task automatic testSingleLine();
		int      errs;
		wbData_t rd;
		errs = errorCount;
		wbWrite(ADDR_DATA, 32'h1A2F);
		waitChars(5);
		checkLine(16'h1A2F);
		repeat (int'(curDiv) + 1) @(negedge iCLK);   // Rest of the stop bit
		wbRead(ADDR_STATUS, rd);
		checkEq("STATUS after line", rd, 0);
		checkEq("extra characters", rxQ.size(), 0);
		reportTest("single line", errs);
	endtask

	task automatic testBackToBack();
		int errs;
		errs = errorCount;
		wbWrite(ADDR_DATA, 32'hBEEF);
		wbWrite(ADDR_DATA, 32'h0C47);   // Held off while the first line goes out
		waitChars(10);
		checkLine(16'hBEEF);
		checkLine(16'h0C47);
		reportTest("back-pressure", errs);
	endtask

	task automatic testStatus();
		int      errs;
		wbData_t rd;
		errs = errorCount;
		wbWrite(ADDR_DATA, 32'h5A09);
		wbRead(ADDR_STATUS, rd);
		checkEq("STATUS busy", |rd[1:0], 1'b1);
		waitChars(5);
		checkLine(16'h5A09);
		repeat (int'(curDiv) + 1) @(negedge iCLK);
		wbRead(ADDR_STATUS, rd);
		checkEq("STATUS idle", rd, 0);
		reportTest("status bits", errs);
	endtask

	task automatic testRandomWords();
		int       errs;
		logWord_t w;
		errs = errorCount;
		for (int i = 0; i < 5; i++)
		begin
			w = logWord_t'($random(seed));
			wbWrite(ADDR_DATA, wbData_t'(w));
			waitChars(5);
			checkLine(w);
		end
		reportTest("random words", errs);
	endtask

	// Watchdog
	initial
	begin
		while (cycleCount < CYCLE_LIMIT)
		begin
			@(posedge iCLK);
			cycleCount++;
		end
		$display("Run stopped after %0d cycles without finishing", CYCLE_LIMIT);
		$display("TESTS FAILED");
		$finish;
	end

	initial
	begin
		iRST   = 1'b1;
		wbCyc  = 1'b0;
		wbStb  = 1'b0;
		wbWe   = 1'b0;
		wbAdr  = '0;
		wbDatW = '0;
		repeat (3) @(posedge iCLK);
		iRST <= 1'b0;
		testReset();
		testRegisters();
		testSingleLine();
		testBackToBack();
		testStatus();
		testRandomWords();
		$display("Checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0)
		begin
			$display("TESTS PASSED");
		end
		else
		begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

// ==== uartTx.sv ====
// --------------------
// 8N1 UART transmitter, LSB first, idle line high
// One bit lasts baudDiv + 1 clocks, divisor taken at frame start
// --------------------
`timescale 1ns/100ps

module uartTx (
	input  logic                  iCLK,
	input  logic                  iRST,
	// Character input
	input  logic                  charValid,
	output logic                  charReady,
	input  hexLogPkg::asciiChar_t char,
	// Configuration and status
	input  hexLogPkg::baudDiv_t   baudDiv,
	output logic                  txBusy,
	// Serial line
	output logic                  txLine
);

	import hexLogPkg::*;

	txState_t   state;
	baudDiv_t   baudCnt;
	baudDiv_t   divLatch;   // Divisor for the current frame
	logic [2:0] bitCnt;
	asciiChar_t shiftReg;
	logic       bitEnd;
	logic       charXfer;

	assign charReady = (state == TX_IDLE);
	assign txBusy    = (state != TX_IDLE);
	assign charXfer  = charValid & charReady;
	assign bitEnd    = (baudCnt == divLatch);

	// --------------------
	// Frame sequencer
	// --------------------
	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			state   <= TX_IDLE;
			baudCnt <= '0;
			bitCnt  <= '0;
		end
		else if (state == TX_IDLE)
		begin
			baudCnt <= '0;
			bitCnt  <= '0;
			if (charValid) state <= TX_START;
		end
		else
		begin
			baudCnt <= bitEnd ? '0 : baudCnt + 1'b1;
			if (bitEnd)
			begin
				case (state)
					TX_START: state <= TX_DATA;
					TX_DATA:
					begin
						bitCnt <= bitCnt + 1'b1;
						if (bitCnt == 3'd7) state <= TX_STOP;
					end
					default:  state <= TX_IDLE;   // End of stop bit
				endcase
			end
		end
	end

	// Data shifter
	always_ff @(posedge iCLK)
	begin
		if (charXfer)
		begin
			shiftReg <= char;
			divLatch <= baudDiv;
		end
		else if ((state == TX_DATA) && bitEnd)
		begin
			shiftReg <= {1'b1, shiftReg[CHAR_WIDTH-1:1]};
		end
	end

	// Line driver
	always_comb
	begin
		case (state)
			TX_START: txLine = 1'b0;
			TX_DATA:  txLine = shiftReg[0];
			default:  txLine = 1'b1;   // Idle and stop
		endcase
	end

endmodule
